// ==== hw/cache_pkg.sv ====
package cache_pkg;

    ////////////////////
    // Widths
    ////////////////////

    // Byte addresses, words sit 2 bytes apart
    localparam int ADDR_W = 16;
    localparam int DATA_W = 16;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    ////////////////////
    // Block geometry
    ////////////////////

    // Word offset is addr[3:1], bit 0 ignored
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_W       = 3;

    // Miss controller states
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        FILL_I = 2'b01,
        FILL_D = 2'b10,
        FINISH = 2'b11
    } ctrl_state_e;

endpackage

// ==== hw/fill_if.sv ====
`timescale 1ns/1ps

// One refill word on its way from the miss controller into a cache
interface fill_if import cache_pkg::*; ();

    word_t fill_data;
    addr_t fill_addr;
    // Word write into the data array
    logic  data_we;
    // Tag write plus valid set
    logic  meta_we;

    modport ctrl (
        output fill_data,
        output fill_addr,
        output data_we,
        output meta_we
    );

    modport cache (
        input fill_data,
        input fill_addr,
        input data_we,
        input meta_we
    );

endinterface

// ==== hw/main_mem.sv ====
`timescale 1ns/1ps

module main_mem import cache_pkg::*; #(
    parameter int MEM_WORDS   = 1024,
    parameter int MEM_LATENCY = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  load_we,
    input  addr_t load_addr,
    input  word_t load_data,
    input  logic  mem_en,
    input  addr_t mem_addr,
    output word_t mem_rdata,
    output logic  mem_vld
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t            mem [MEM_WORDS];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] ld_idx;

    // One valid/data pair per latency stage
    logic  vld_pipe  [MEM_LATENCY];
    word_t data_pipe [MEM_LATENCY];

    // Word index, upper address bits wrap
    assign rd_idx = mem_addr[IDX_W:1];
    assign ld_idx = load_addr[IDX_W:1];

    // Loader port, only used while the core is held off
    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[ld_idx] <= load_data;
        end
    end

    ////////////////////
    // Read pipeline
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_LATENCY; i++) begin
                vld_pipe[i] <= 1'b0;
            end
        end else begin
            vld_pipe[0] <= mem_en;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[rd_idx];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign mem_rdata = data_pipe[MEM_LATENCY-1];
    assign mem_vld   = vld_pipe[MEM_LATENCY-1];

endmodule

// ==== hw/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; #(
    parameter int MEM_LATENCY = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  i_miss,
    input  addr_t i_addr,
    input  logic  d_miss,
    input  addr_t d_addr,
    output logic  mem_en,
    output addr_t mem_addr,
    input  word_t mem_rdata,
    input  logic  mem_vld,
    fill_if.ctrl  fill_i,
    fill_if.ctrl  fill_d,
    output logic  stall
);

    // Block number is everything above the word offset
    localparam int BLK_W = ADDR_W - OFFSET_W - 1;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    logic [BLK_W-1:0]    blk_q;
    addr_t               miss_addr;
    logic [OFFSET_W:0]   issue_cnt;
    logic [OFFSET_W-1:0] ret_cnt;
    addr_t               addr_pipe [MEM_LATENCY];
    addr_t               fill_addr;

    logic filling;
    logic entering;
    logic last_word;

    assign filling   = (state_q == FILL_I) || (state_q == FILL_D);
    assign last_word = filling && mem_vld &&
                       (ret_cnt == OFFSET_W'(WORDS_PER_LINE - 1));

    ////////////////////
    // FSM
    ////////////////////

    // Instruction side wins when both miss together
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_miss) begin
                    state_d = FILL_I;
                end else if (d_miss) begin
                    state_d = FILL_D;
                end
            end
            FILL_I: begin
                if (last_word) begin
                    state_d = d_miss ? FILL_D : FINISH;
                end
            end
            FILL_D: begin
                if (last_word) begin
                    state_d = FINISH;
                end
            end
            FINISH: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign entering  = ((state_d == FILL_I) || (state_d == FILL_D)) && (state_d != state_q);
    assign miss_addr = (state_d == FILL_I) ? i_addr : d_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= IDLE;
            issue_cnt <= '0;
            ret_cnt   <= '0;
        end else begin
            state_q <= state_d;
            if (entering) begin
                issue_cnt <= '0;
                ret_cnt   <= '0;
            end else begin
                if (mem_en) begin
                    issue_cnt <= issue_cnt + 1'b1;
                end
                if (filling && mem_vld) begin
                    ret_cnt <= ret_cnt + 1'b1;
                end
            end
        end
    end

    // Block base of the line being fetched
    always_ff @(posedge clk) begin
        if (entering) begin
            blk_q <= miss_addr[ADDR_W-1:OFFSET_W+1];
        end
    end

    ////////////////////
    // Memory requests
    ////////////////////

    // Eight back to back reads, stop once the counter hits 8
    assign mem_en   = filling && !issue_cnt[OFFSET_W];
    assign mem_addr = {blk_q, issue_cnt[OFFSET_W-1:0], 1'b0};

    // Delay line so each address meets its returning word
    always_ff @(posedge clk) begin
        addr_pipe[0] <= mem_addr;
        for (int i = 1; i < MEM_LATENCY; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    assign fill_addr = addr_pipe[MEM_LATENCY-1];

    ////////////////////
    // Cache fills
    ////////////////////

    assign fill_i.fill_data = mem_rdata;
    assign fill_i.fill_addr = fill_addr;
    assign fill_i.data_we   = (state_q == FILL_I) && mem_vld;
    assign fill_i.meta_we   = (state_q == FILL_I) && last_word;

    assign fill_d.fill_data = mem_rdata;
    assign fill_d.fill_addr = fill_addr;
    assign fill_d.data_we   = (state_q == FILL_D) && mem_vld;
    assign fill_d.meta_we   = (state_q == FILL_D) && last_word;

    // Held until both sides hit and the FSM is back home
    assign stall = i_miss || d_miss || (state_q != IDLE);

endmodule

// ==== hw/direct_cache.sv ====
`timescale 1ns/1ps

module direct_cache import cache_pkg::*; #(
    parameter int NUM_LINES = 8
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  rd,
    input  addr_t addr,
    output word_t rdata,
    output logic  miss,
    fill_if.cache fill
);

    localparam int INDEX_W = $clog2(NUM_LINES);
    localparam int TAG_LSB = OFFSET_W + INDEX_W + 1;
    localparam int TAG_W   = ADDR_W - TAG_LSB;

    // Storage
    word_t            data_mem [NUM_LINES][WORDS_PER_LINE];
    logic [TAG_W-1:0] tag_mem  [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;

    // Lookup fields
    logic [INDEX_W-1:0]  rd_idx;
    logic [OFFSET_W-1:0] rd_off;
    logic [TAG_W-1:0]    rd_tag;
    logic                hit;

    // Fill fields
    logic [INDEX_W-1:0]  fl_idx;
    logic [OFFSET_W-1:0] fl_off;
    logic [TAG_W-1:0]    fl_tag;

    ////////////////////
    // Lookup
    ////////////////////

    assign rd_off = addr[OFFSET_W:1];
    assign rd_idx = addr[TAG_LSB-1:OFFSET_W+1];
    assign rd_tag = addr[ADDR_W-1:TAG_LSB];

    assign hit   = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign miss  = rd && !hit;
    assign rdata = hit ? data_mem[rd_idx][rd_off] : '0;

    ////////////////////
    // Refill
    ////////////////////

    assign fl_off = fill.fill_addr[OFFSET_W:1];
    assign fl_idx = fill.fill_addr[TAG_LSB-1:OFFSET_W+1];
    assign fl_tag = fill.fill_addr[ADDR_W-1:TAG_LSB];

    always_ff @(posedge clk) begin
        if (fill.data_we) begin
            data_mem[fl_idx][fl_off] <= fill.fill_data;
        end
    end

    always_ff @(posedge clk) begin
        if (fill.meta_we) begin
            tag_mem[fl_idx] <= fl_tag;
        end
    end

    // Line only turns valid once the last word is in
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill.meta_we) begin
            valid_q[fl_idx] <= 1'b1;
        end
    end

endmodule

// ==== hw/mem_system.sv ====
`timescale 1ns/1ps

module mem_system import cache_pkg::*; #(
    parameter int NUM_LINES   = 8,
    parameter int MEM_LATENCY = 4,
    parameter int MEM_WORDS   = 1024
) (
    input  logic  clk,
    input  logic  rst,
    // Instruction port
    input  logic  i_rd,
    input  addr_t i_addr,
    output word_t i_rdata,
    // Data port
    input  logic  d_rd,
    input  addr_t d_addr,
    output word_t d_rdata,
    output logic  stall,
    // Loader
    input  logic  load_we,
    input  addr_t load_addr,
    input  word_t load_data
);

    logic  i_miss;
    logic  d_miss;
    logic  mem_en;
    addr_t mem_addr;
    word_t mem_rdata;
    logic  mem_vld;

    fill_if fill_i ();
    fill_if fill_d ();

    ////////////////////
    // Caches
    ////////////////////

    direct_cache #(
        .NUM_LINES (NUM_LINES)
    ) i_icache (
        .clk   (clk),
        .rst   (rst),
        .rd    (i_rd),
        .addr  (i_addr),
        .rdata (i_rdata),
        .miss  (i_miss),
        .fill  (fill_i.cache)
    );

    direct_cache #(
        .NUM_LINES (NUM_LINES)
    ) i_dcache (
        .clk   (clk),
        .rst   (rst),
        .rd    (d_rd),
        .addr  (d_addr),
        .rdata (d_rdata),
        .miss  (d_miss),
        .fill  (fill_d.cache)
    );

    // Miss handling and shared memory
    cache_ctrl #(
        .MEM_LATENCY (MEM_LATENCY)
    ) i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .i_miss    (i_miss),
        .i_addr    (i_addr),
        .d_miss    (d_miss),
        .d_addr    (d_addr),
        .mem_en    (mem_en),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .mem_vld   (mem_vld),
        .fill_i    (fill_i.ctrl),
        .fill_d    (fill_d.ctrl),
        .stall     (stall)
    );

    main_mem #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) i_mem (
        .clk       (clk),
        .rst       (rst),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .mem_en    (mem_en),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .mem_vld   (mem_vld)
    );

endmodule

// ==== verif/tb_mem_system.sv ====
`timescale 1ns/1ps

module tb_mem_system import cache_pkg::*; ();

    localparam int PERIOD      = 100;
    localparam int WAIT_LIMIT  = 500;
    localparam int MODEL_WORDS = 1024;
    localparam int NUM_RANDOM  = 200;

    logic  clk;
    logic  rst;
    logic  i_rd;
    addr_t i_addr;
    word_t i_rdata;
    logic  d_rd;
    addr_t d_addr;
    word_t d_rdata;
    logic  stall;
    logic  load_we;
    addr_t load_addr;
    word_t load_data;

    // Reference copy of main memory
    word_t model [MODEL_WORDS];

    // Expected stall in the first cycle of a request
    logic exp_miss;
    logic exp_hit;
    logic stall_seen;

    int    err_cnt = 0;
    int    timeout_cnt = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    test_base = 0;
    string cur_test = "reset";

    mem_system i_dut (
        .clk       (clk),
        .rst       (rst),
        .i_rd      (i_rd),
        .i_addr    (i_addr),
        .i_rdata   (i_rdata),
        .d_rd      (d_rd),
        .d_addr    (d_addr),
        .d_rdata   (d_rdata),
        .stall     (stall),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // Stall as seen by the checks at each rising edge
    always @(posedge clk) begin
        stall_seen <= stall;
    end

    ////////////////////
    // Checks
    ////////////////////

    a_i_data: assert property (@(posedge clk) disable iff (rst)
        (i_rd && !stall) |-> (i_rdata == model[i_addr[10:1]]))
    else begin
        err_cnt++;
        $display("[ERROR] %s: i_rdata at %h expected %h actual %h", cur_test,
                 $sampled(i_addr), model[$sampled(i_addr[10:1])], $sampled(i_rdata));
    end

    a_d_data: assert property (@(posedge clk) disable iff (rst)
        (d_rd && !stall) |-> (d_rdata == model[d_addr[10:1]]))
    else begin
        err_cnt++;
        $display("[ERROR] %s: d_rdata at %h expected %h actual %h", cur_test,
                 $sampled(d_addr), model[$sampled(d_addr[10:1])], $sampled(d_rdata));
    end

    a_miss_stall: assert property (@(posedge clk) disable iff (rst) exp_miss |-> stall)
    else begin
        err_cnt++;
        $display("[ERROR] %s: stall on miss expected %b actual %b", cur_test,
                 1'b1, $sampled(stall));
    end

    a_hit_no_stall: assert property (@(posedge clk) disable iff (rst) exp_hit |-> !stall)
    else begin
        err_cnt++;
        $display("[ERROR] %s: stall on hit expected %b actual %b", cur_test,
                 1'b0, $sampled(stall));
    end

    // No request means nothing to wait for
    a_idle_no_stall: assert property (@(posedge clk) disable iff (rst)
        (!i_rd && !d_rd) |-> !stall)
    else begin
        err_cnt++;
        $display("[ERROR] %s: stall while idle expected %b actual %b", cur_test,
                 1'b0, $sampled(stall));
    end

    ////////////////////
    // Stimulus helpers
    ////////////////////

    task automatic load_memory();
        for (int k = 0; k < MODEL_WORDS; k++) begin
            load_we   = 1'b1;
            load_addr = addr_t'(k * 2);
            load_data = model[k];
            @(negedge clk);
        end
        load_we = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Hold the request until a rising edge sees stall low
    task automatic read_until_ready(input logic use_i, input addr_t ia, input logic use_d,
                                    input addr_t da, input logic want_miss,
                                    input logic want_hit);
        int cycles;
        i_rd     = use_i;
        i_addr   = ia;
        d_rd     = use_d;
        d_addr   = da;
        exp_miss = want_miss;
        exp_hit  = want_hit;
        cycles   = 0;
        do begin
            @(negedge clk);
            exp_miss = 1'b0;
            exp_hit  = 1'b0;
            cycles++;
        end while (stall_seen && cycles < WAIT_LIMIT);
        if (stall_seen) begin
            timeout_cnt++;
            $display("%s: stall did not fall within %0d cycles (i_addr %h, d_addr %h)",
                     cur_test, WAIT_LIMIT, ia, da);
        end
        i_rd = 1'b0;
        d_rd = 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_base = err_cnt + timeout_cnt;
    endtask

    task automatic finish_test();
        int errs;
        errs = err_cnt + timeout_cnt - test_base;
        tests_run++;
        if (errs == 0) begin
            $display("%s: PASS", cur_test);
        end else begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", cur_test, errs);
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        logic  use_i;
        logic  use_d;
        addr_t ia;
        addr_t da;

        void'($urandom(32'h24f25a81));
        for (int k = 0; k < MODEL_WORDS; k++) begin
            model[k] = word_t'($urandom());
        end

        rst       = 1'b1;
        i_rd      = 1'b0;
        i_addr    = '0;
        d_rd      = 1'b0;
        d_addr    = '0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        exp_miss  = 1'b0;
        exp_hit   = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        load_memory();

        start_test("reset_and_first_miss");
        idle_cycles(8);
        read_until_ready(1'b1, 16'h0010, 1'b0, 16'h0000, 1'b1, 1'b0);
        read_until_ready(1'b0, 16'h0000, 1'b1, 16'h0010, 1'b1, 1'b0);
        finish_test();

        start_test("instruction_miss");
        read_until_ready(1'b1, 16'h0024, 1'b0, 16'h0000, 1'b1, 1'b0);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (w != 2) begin
                read_until_ready(1'b1, addr_t'(16'h0020 + w * 2), 1'b0, 16'h0000, 1'b0, 1'b1);
            end
        end
        finish_test();

        start_test("data_miss");
        read_until_ready(1'b0, 16'h0000, 1'b1, 16'h0136, 1'b1, 1'b0);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (w != 3) begin
                read_until_ready(1'b0, 16'h0000, 1'b1, addr_t'(16'h0130 + w * 2), 1'b0, 1'b1);
            end
        end
        finish_test();

        start_test("dual_miss");
        read_until_ready(1'b1, 16'h0250, 1'b1, 16'h0358, 1'b1, 1'b0);
        read_until_ready(1'b1, 16'h0252, 1'b1, 16'h035a, 1'b0, 1'b1);
        finish_test();

        // Same index 6, tags differ
        start_test("line_conflict");
        read_until_ready(1'b1, 16'h0064, 1'b0, 16'h0000, 1'b1, 1'b0);
        read_until_ready(1'b1, 16'h00e4, 1'b0, 16'h0000, 1'b1, 1'b0);
        read_until_ready(1'b1, 16'h0064, 1'b0, 16'h0000, 1'b1, 1'b0);
        finish_test();

        start_test("random_reads");
        for (int n = 0; n < NUM_RANDOM; n++) begin
            use_i = 1'($urandom_range(0, 1));
            use_d = 1'($urandom_range(0, 1));
            if (!use_i && !use_d) begin
                use_d = 1'b1;
            end
            ia = addr_t'($urandom_range(0, 511));
            da = addr_t'($urandom_range(0, 511));
            read_until_ready(use_i, ia, use_d, da, 1'b0, 1'b0);
            if (timeout_cnt != 0) begin
                break;
            end
        end
        finish_test();

        $display("%0d tests run, %0d passed, %0d failed, %0d errors, %0d timeouts",
                 tests_run, tests_run - tests_failed, tests_failed, err_cnt, timeout_cnt);
        if (tests_failed == 0 && err_cnt == 0 && timeout_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hw/cache_pkg.sv
hw/fill_if.sv
hw/main_mem.sv
hw/cache_ctrl.sv
hw/direct_cache.sv
hw/mem_system.sv
verif/tb_mem_system.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_system -f build.f -o tb_mem_system

./obj_dir/tb_mem_system > sim.log 2>&1
cat sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
